/* dv/adc_link_chk.sv */
// assertions on the ADC link, bound into adc_link_top
// link state and serializer activity come from inside the top level
`include "adc_link_config.svh"
`timescale 1ns/1ps
`default_nettype none

module adc_link_chk import adc_link_pkg::*; (
	input logic                        clock,
	input logic                        reset,
	input link_state_t                 link_state,
	input logic                        tx_start,
	input logic                        tx_active,
	input logic [`ADC_LINK_CHAN_W-1:0] canale,
	input logic                        load_dato,
	input logic                        mux_en,
	input logic                        error
);

	// link loads and starts only while the serializer is idle
	load_send_apart: assert property (@(posedge clock) disable iff (reset)
		(link_state == link_load || tx_start) |-> !tx_active)
		else $error("link loaded or started a frame while a frame was shifted out");

	canale_in_range: assert property (@(posedge clock) disable iff (reset)
		int'(canale) < `ADC_LINK_CHANNELS)
		else $error("canale is outside the channel range");

	// mux stays on through the conversion and drops in the load cycle
	mux_off_at_load: assert property (@(posedge clock) disable iff (reset)
		load_dato |-> !mux_en && $past(mux_en))
		else $error("mux_en not released exactly at load_dato");

	no_error_while_shifting: assert property (@(posedge clock) disable iff (reset)
		tx_active |-> !error)
		else $error("error high while a frame is shifted out");

endmodule

bind adc_link_top adc_link_chk i_adc_link_chk (
	.clock      (clock),
	.reset      (reset),
	.link_state (i_serial_link.state),
	.tx_start   (tx_start),
	.tx_active  (i_uart_serializer.active),
	.canale     (canale),
	.load_dato  (load_dato),
	.mux_en     (mux_en),
	.error      (error)
);

`default_nettype wire

/* dv/adc_link_tb.sv */
// testbench for the ADC link, stimulus and expected bytes come from dv/adc_link_trace.txt
// run from the project root so that the trace path resolves
// ADC model and serial decoder count cycles of the 40 ns clock
`include "adc_link_config.svh"
`timescale 1ns/1ps
`default_nettype none

module adc_link_tb;

	localparam int bit_clocks = `ADC_LINK_BIT_TICKS + 1;
	localparam longint clock_ns = 40;

	logic                        clock;
	logic                        reset;
	logic                        eoc;
	logic                        dsr;
	logic [7:0]                  data_in;
	logic                        soc;
	logic                        load_dato;
	logic                        mux_en;
	logic                        add_mpx2;
	logic                        error;
	logic                        data_out;
	logic [`ADC_LINK_CHAN_W-1:0] canale;

	// trace columns, one entry per sample
	logic [7:0]                  tr_sample[$];
	logic                        tr_dsr_hdr[$];
	logic                        tr_dsr_dat[$];
	logic [`ADC_LINK_CHAN_W-1:0] tr_chan[$];
	logic [7:0]                  tr_header[$];
	logic [7:0]                  tr_data[$];

	// frames that must still show up on the line, oldest first
	logic [7:0]  exp_byte_q[$];
	logic        exp_mpx_q[$];
	int          frames_expected;
	int          frames_done;
	int          error_count = 0;
	logic [15:0] lfsr_state;

	adc_link_top i_adc_link_top (
		.clock     (clock),
		.reset     (reset),
		.eoc       (eoc),
		.dsr       (dsr),
		.data_in   (data_in),
		.soc       (soc),
		.load_dato (load_dato),
		.mux_en    (mux_en),
		.add_mpx2  (add_mpx2),
		.error     (error),
		.data_out  (data_out),
		.canale    (canale)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#20 clock = ~clock;
		end
	end

	task automatic abort_run();
		error_count++;
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			abort_run();
		end
	endtask

	// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one LFSR step for every bit taken
	function automatic int unsigned random_bits(input int count);
		logic [31:0] r;
		int          k;
		r = '0;
		for (k = 0; k < count; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	task automatic read_trace();
		int                          fd;
		int                          n;
		string                       line;
		logic [7:0]                  smp;
		logic [7:0]                  hdr;
		logic [7:0]                  dat;
		logic                        dh;
		logic                        dd;
		logic [`ADC_LINK_CHAN_W-1:0] ch;
		fd = $fopen("dv/adc_link_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open dv/adc_link_trace.txt");
			abort_run();
		end
		while ($fgets(line, fd) != 0) begin
			// comment lines start with #
			if (line[0] == "#") begin
				continue;
			end
			n = $sscanf(line, "%h %h %h %h %h %h", smp, dh, dd, ch, hdr, dat);
			if (n == 6) begin
				tr_sample.push_back(smp);
				tr_dsr_hdr.push_back(dh);
				tr_dsr_dat.push_back(dd);
				tr_chan.push_back(ch);
				tr_header.push_back(hdr);
				tr_data.push_back(dat);
			end
		end
		$fclose(fd);
		if (tr_sample.size() == 0) begin
			$display("the trace file holds no samples");
			abort_run();
		end
	endtask

	// entered in the first cycle of a start bit, leaves in the last cycle of the stop bit
	task automatic decode_frame();
		logic [7:0] exp_byte;
		logic       exp_mpx;
		logic [7:0] got;
		logic       first;
		logic       mid;
		int         b;
		int         c;
		if (exp_byte_q.size() == 0) begin
			$display("a frame appeared on data_out although the trace expects none");
			abort_run();
		end
		exp_byte = exp_byte_q.pop_front();
		exp_mpx = exp_mpx_q.pop_front();
		got = 8'h00;
		for (b = 0; b < 10; b++) begin
			if (b > 0) begin
				@(negedge clock);
			end
			first = data_out;
			mid = data_out;
			for (c = 1; c < bit_clocks; c++) begin
				@(negedge clock);
				// level holds for exactly one bit time
				check_value("data_out", 32'(data_out), 32'(first));
				if (c == bit_clocks / 2) begin
					mid = data_out;
					check_value("add_mpx2", 32'(add_mpx2), 32'(exp_mpx));
				end
			end
			if (b == 9) begin
				check_value("stop bit", 32'(mid), 32'h1);
			end else if (b > 0) begin
				// MSB arrives first
				got = {got[6:0], mid};
			end
		end
		check_value("frame byte", 32'(got), 32'(exp_byte));
		frames_done++;
	endtask

	// ADC model, busy after a random wait, byte valid while eoc is high
	initial begin : adc_model
		int unsigned wait_cycles;
		int unsigned busy_cycles;
		int          conv_idx;
		eoc <= 1'b0;
		data_in <= 8'h00;
		lfsr_state = 16'd46017;
		conv_idx = 0;
		forever begin
			@(negedge clock);
			if (!reset && soc) begin
				wait_cycles = 1 + random_bits(3);
				busy_cycles = 2 + random_bits(3);
				repeat (wait_cycles) begin
					@(posedge clock);
				end
				eoc <= 1'b1;
				data_in <= tr_sample[conv_idx % tr_sample.size()];
				repeat (busy_cycles) begin
					@(posedge clock);
				end
				eoc <= 1'b0;
				conv_idx++;
				while (soc) begin
					@(negedge clock);
				end
			end
		end
	end

	initial begin : line_decoder
		frames_done = 0;
		forever begin
			@(negedge clock);
			if (!reset && data_out === 1'b0) begin
				decode_frame();
			end
		end
	end

	initial begin : watchdog
		longint limit_ns;
		@(posedge clock);
		// two frames of ten bits per sample, plus room for reset and conversions
		limit_ns = longint'(tr_sample.size()) * 2 * 10 * bit_clocks * clock_ns
			+ (longint'(tr_sample.size()) * 200 + 1000) * clock_ns;
		#(limit_ns);
		$display("the run timed out after %0d ns before the trace was finished", limit_ns);
		abort_run();
	end

	initial begin : main_sequence
		int   idx;
		logic prev_dsr_dat;
		reset <= 1'b1;
		dsr <= 1'b0;
		frames_expected = 0;
		// no data frame before the first sample, so error starts low
		prev_dsr_dat = 1'b1;
		read_trace();
		repeat (15) begin
			@(posedge clock);
		end
		@(negedge clock);
		check_value("soc", 32'(soc), 32'h0);
		check_value("load_dato", 32'(load_dato), 32'h0);
		check_value("mux_en", 32'(mux_en), 32'h0);
		check_value("add_mpx2", 32'(add_mpx2), 32'h0);
		check_value("error", 32'(error), 32'h0);
		check_value("data_out", 32'(data_out), 32'h1);
		@(posedge clock);
		reset <= 1'b0;
		for (idx = 0; idx < tr_sample.size(); idx++) begin
			while (!soc) begin
				@(negedge clock);
			end
			// a new conversion only once the previous sample is fully out
			check_value("frames done at soc", 32'(frames_done), 32'(frames_expected));
			check_value("add_mpx2 at soc", 32'(add_mpx2), 32'h0);
			check_value("error at soc", 32'(error), 32'(!prev_dsr_dat));
			// mux already selects the channel when the conversion starts
			check_value("mux_en at soc", 32'(mux_en), 32'h1);
			while (!load_dato) begin
				@(negedge clock);
			end
			if (tr_dsr_hdr[idx]) begin
				exp_byte_q.push_back(tr_header[idx]);
				exp_mpx_q.push_back(1'b0);
				frames_expected++;
			end
			if (tr_dsr_dat[idx]) begin
				exp_byte_q.push_back(tr_data[idx]);
				exp_mpx_q.push_back(1'b1);
				frames_expected++;
			end
			@(posedge clock);
			dsr <= tr_dsr_hdr[idx];
			@(negedge clock);
			check_value("canale", 32'(canale), 32'(tr_chan[idx]));
			check_value("trace channel", 32'(tr_chan[idx]),
				32'((idx + 1) % `ADC_LINK_CHANNELS));
			check_value("trace header", 32'(tr_header[idx]),
				32'({`ADC_LINK_HDR_TAG, tr_chan[idx]}));
			// add_mpx2 rises with the data frame shot, header decision is behind us
			while (!add_mpx2) begin
				@(negedge clock);
			end
			check_value("error after header", 32'(error), 32'(!tr_dsr_hdr[idx]));
			@(posedge clock);
			dsr <= tr_dsr_dat[idx];
			prev_dsr_dat = tr_dsr_dat[idx];
		end
		// next soc shows that both frames of the last sample are finished
		while (!soc) begin
			@(negedge clock);
		end
		check_value("frames done at end", 32'(frames_done), 32'(frames_expected));
		check_value("add_mpx2 at end", 32'(add_mpx2), 32'h0);
		check_value("error at end", 32'(error), 32'(!prev_dsr_dat));
		if (error_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* dv/adc_link_trace.txt */
# columns in hex: sample dsr_header dsr_data channel header_byte data_byte
# one line per ADC conversion, channel starts at 1 after reset
3C 1 1 1 A1 3C
55 1 1 2 A2 55
AA 1 1 3 A3 AA
00 0 1 4 A4 00
FF 1 1 5 A5 FF
81 1 0 6 A6 81
7E 1 1 7 A7 7E
12 0 0 0 A0 12
96 1 1 1 A1 96
C3 1 1 2 A2 C3
5A 0 1 3 A3 5A
01 1 0 4 A4 01
80 1 1 5 A5 80
E7 1 1 6 A6 E7

/* filelist.f */
+incdir+logic
logic/adc_link_pkg.sv
logic/sample_if.sv
logic/frame_if.sv
logic/acq_sequencer.sv
logic/frame_dispatcher.sv
logic/serial_link.sv
logic/uart_serializer.sv
logic/adc_link_top.sv
dv/adc_link_chk.sv
dv/adc_link_tb.sv

/* logic/acq_sequencer.sv */
// drives the external multiplexed ADC through one conversion per sample
// eoc must rise and then fall, data_in is sampled on the falling edge of eoc
// next conversion starts only after the dispatcher releases the sample
`include "adc_link_config.svh"
`timescale 1ns/1ps
`default_nettype none

module acq_sequencer import adc_link_pkg::*; (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        eoc,
	input  logic [7:0]                  data_in,
	output logic                        soc,
	output logic                        load_dato,
	output logic                        mux_en,
	output logic [`ADC_LINK_CHAN_W-1:0] canale,
	sample_if.source                    smp
);

	localparam int chan_w = `ADC_LINK_CHAN_W;
	localparam logic [chan_w-1:0] chan_last = chan_w'(`ADC_LINK_CHANNELS - 1);

	acq_state_t        state;
	logic [chan_w-1:0] chan_cnt;
	logic [chan_w-1:0] chan_next;
	logic              conv_done;

	// channel counter wraps at the channel count
	assign chan_next = (chan_cnt == chan_last) ? '0 : chan_cnt + 1'b1;
	// falling eoc after it was seen high
	assign conv_done = (state == acq_wait_done) && !eoc;

	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= acq_mux_on;
			soc       <= 1'b0;
			load_dato <= 1'b0;
			mux_en    <= 1'b0;
			canale    <= '0;
			chan_cnt  <= '0;
			smp.valid <= 1'b0;
		end else begin
			// load_dato is a single pulse
			load_dato <= 1'b0;
			case (state)
				acq_mux_on: begin
					mux_en <= 1'b1;
					state  <= acq_settle;
				end
				// one cycle for the mux to settle
				acq_settle: state <= acq_start;
				acq_start: begin
					soc   <= 1'b1;
					state <= acq_wait_busy;
				end
				// converter signals busy with eoc high
				acq_wait_busy: begin
					if (eoc) begin
						state <= acq_wait_done;
					end
				end
				acq_wait_done: begin
					if (!eoc) begin
						load_dato <= 1'b1;
						mux_en    <= 1'b0;
						chan_cnt  <= chan_next;
						state     <= acq_load;
					end
				end
				acq_load: begin
					soc       <= 1'b0;
					canale    <= chan_cnt;
					smp.valid <= 1'b1;
					state     <= acq_hand_off;
				end
				// wait for the dispatcher to take the sample
				acq_hand_off: begin
					if (smp.ready) begin
						state <= acq_wait_ready;
					end
				end
				// ready low again means both frames are finished
				acq_wait_ready: begin
					if (!smp.ready) begin
						smp.valid <= 1'b0;
						state     <= acq_mux_on;
					end
				end
				default: state <= acq_mux_on;
			endcase
		end
	end

	// sample payload, held until the next conversion ends
	always_ff @(posedge clock) begin
		if (conv_done) begin
			smp.data    <= data_in;
			smp.channel <= chan_next;
		end
	end

endmodule

`default_nettype wire

/* logic/adc_link_config.svh */
// shared constants for the ADC link
// bit time is ADC_LINK_BIT_TICKS+1 clocks, so change it only with the line rate in mind
// channel width must hold ADC_LINK_CHANNELS-1 and leave room for the header tag in 8 bits
`ifndef ADC_LINK_CONFIG_SVH
`define ADC_LINK_CONFIG_SVH

// counter limit per serial bit
`define ADC_LINK_BIT_TICKS 104
// multiplexer channels, channel number wraps at this value
`define ADC_LINK_CHANNELS 8
`define ADC_LINK_CHAN_W 4
// high nibble of every header frame
`define ADC_LINK_HDR_TAG 4'hA

`endif

/* logic/adc_link_pkg.sv */
// state and position types shared by the ADC link blocks
// encodings are fixed, the serializer relies on consecutive bit positions
`default_nettype none

package adc_link_pkg;

	// acquisition sequencer
	typedef enum logic [2:0] {
		acq_mux_on     = 3'd0,
		acq_settle     = 3'd1,
		acq_start      = 3'd2,
		acq_wait_busy  = 3'd3,
		acq_wait_done  = 3'd4,
		acq_load       = 3'd5,
		acq_hand_off   = 3'd6,
		acq_wait_ready = 3'd7
	} acq_state_t;

	// frame dispatcher
	typedef enum logic [1:0] {
		disp_idle         = 2'd0,
		disp_shot         = 2'd1,
		disp_wait_confirm = 2'd2,
		disp_done         = 2'd3
	} disp_state_t;

	// link handshake
	typedef enum logic [1:0] {
		link_idle     = 2'd0,
		link_load     = 2'd1,
		link_send     = 2'd2,
		link_wait_end = 2'd3
	} link_state_t;

	// serializer bit position, start bit first, data MSB first
	typedef enum logic [3:0] {
		tx_start = 4'd0,
		tx_bit0  = 4'd1,
		tx_bit1  = 4'd2,
		tx_bit2  = 4'd3,
		tx_bit3  = 4'd4,
		tx_bit4  = 4'd5,
		tx_bit5  = 4'd6,
		tx_bit6  = 4'd7,
		tx_bit7  = 4'd8,
		tx_stop  = 4'd9
	} tx_bit_t;

endpackage

`default_nettype wire

/* logic/adc_link_top.sv */
// ADC acquisition link, two serial frames per sample
// dsr is sampled once per frame at the send decision
// single clock domain, eoc and dsr must already be synchronous
`include "adc_link_config.svh"
`timescale 1ns/1ps
`default_nettype none

module adc_link_top (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        eoc,
	input  logic                        dsr,
	input  logic [7:0]                  data_in,
	output logic                        soc,
	output logic                        load_dato,
	output logic                        mux_en,
	output logic                        add_mpx2,
	output logic                        error,
	output logic                        data_out,
	output logic [`ADC_LINK_CHAN_W-1:0] canale
);

	// link to serializer
	logic       tx_start;
	logic [7:0] tx_data;
	logic       tx_done;

	sample_if smp_if ();
	frame_if  frm_if ();

	acq_sequencer i_acq_sequencer (
		.clock     (clock),
		.reset     (reset),
		.eoc       (eoc),
		.data_in   (data_in),
		.soc       (soc),
		.load_dato (load_dato),
		.mux_en    (mux_en),
		.canale    (canale),
		.smp       (smp_if.source)
	);

	frame_dispatcher i_frame_dispatcher (
		.clock    (clock),
		.reset    (reset),
		.smp      (smp_if.sink),
		.frm      (frm_if.master),
		.add_mpx2 (add_mpx2)
	);

	serial_link i_serial_link (
		.clock    (clock),
		.reset    (reset),
		.frm      (frm_if.slave),
		.dsr      (dsr),
		.error    (error),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.tx_done  (tx_done)
	);

	uart_serializer i_uart_serializer (
		.clock    (clock),
		.reset    (reset),
		.start    (tx_start),
		.data     (tx_data),
		.done     (tx_done),
		.data_out (data_out)
	);

endmodule

`default_nettype wire

/* logic/frame_dispatcher.sv */
// splits each sample into a header frame and a data frame
// header is the tag nibble over the channel number
// add_mpx2 marks the data frame and drops together with ready
`include "adc_link_config.svh"
`timescale 1ns/1ps
`default_nettype none

module frame_dispatcher import adc_link_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	sample_if.sink     smp,
	frame_if.master    frm,
	output logic       add_mpx2
);

	localparam logic [7-`ADC_LINK_CHAN_W:0] hdr_tag = `ADC_LINK_HDR_TAG;

	disp_state_t state;
	logic        accept;
	logic        header_done;

	// new sample taken in idle
	assign accept = (state == disp_idle) && smp.valid;
	// header confirmed, data frame next
	assign header_done = (state == disp_wait_confirm) && frm.confirm && !frm.second;

	always_ff @(posedge clock) begin
		if (reset) begin
			state      <= disp_idle;
			smp.ready  <= 1'b0;
			frm.shot   <= 1'b0;
			frm.second <= 1'b0;
			add_mpx2   <= 1'b0;
		end else begin
			frm.shot <= 1'b0;
			case (state)
				disp_idle: begin
					if (smp.valid) begin
						smp.ready  <= 1'b1;
						frm.second <= 1'b0;
						state      <= disp_shot;
					end
				end
				disp_shot: begin
					frm.shot <= 1'b1;
					add_mpx2 <= frm.second;
					state    <= disp_wait_confirm;
				end
				disp_wait_confirm: begin
					if (frm.confirm) begin
						if (!frm.second) begin
							frm.second <= 1'b1;
							state      <= disp_shot;
						end else begin
							// both frames out or dropped, release the sample
							smp.ready  <= 1'b0;
							frm.second <= 1'b0;
							add_mpx2   <= 1'b0;
							state      <= disp_done;
						end
					end
				end
				// lets valid fall before idle looks at it again
				disp_done: state <= disp_idle;
				default: state <= disp_idle;
			endcase
		end
	end

	// frame byte, stable from shot to confirm
	always_ff @(posedge clock) begin
		if (accept) begin
			frm.frame <= {hdr_tag, smp.channel};
		end else if (header_done) begin
			frm.frame <= smp.data;
		end
	end

endmodule

`default_nettype wire

/* logic/frame_if.sv */
// one frame request, dispatcher to link block
// shot and confirm are single-cycle pulses, frame stays put from shot to confirm
// second marks the data frame of a sample
`timescale 1ns/1ps
`default_nettype none

interface frame_if;

	logic       shot;
	logic       confirm;
	logic [7:0] frame;
	logic       second;

	modport master (
		output shot,
		output frame,
		output second,
		input  confirm
	);

	// the link block does not care which frame of the pair it sends
	modport slave (
		input  shot,
		input  frame,
		output confirm
	);

endinterface

`default_nettype wire

/* logic/sample_if.sv */
// one converted sample with its channel, sequencer to dispatcher
// valid holds with data and channel stable until the sink drops ready
// only one sample is ever in flight
`include "adc_link_config.svh"
`timescale 1ns/1ps
`default_nettype none

interface sample_if;

	logic                       valid;
	// high while the dispatcher owns the sample
	logic                       ready;
	logic [7:0]                 data;
	logic [`ADC_LINK_CHAN_W-1:0] channel;

	modport source (
		output valid,
		output data,
		output channel,
		input  ready
	);

	modport sink (
		input  valid,
		input  data,
		input  channel,
		output ready
	);

endinterface

`default_nettype wire

/* logic/serial_link.sv */
// link handshake with the transmit holding register
// a frame is sent only when dsr is high at the send decision
// otherwise it is dropped, error is set and the frame is still confirmed
`timescale 1ns/1ps
`default_nettype none

module serial_link import adc_link_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	frame_if.slave     frm,
	input  logic       dsr,
	output logic       error,
	output logic       tx_start,
	output logic [7:0] tx_data,
	input  logic       tx_done
);

	link_state_t state;
	// transmit holding register
	logic [7:0]  hold_reg;

	assign tx_data = hold_reg;

	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= link_idle;
			error       <= 1'b0;
			tx_start    <= 1'b0;
			frm.confirm <= 1'b0;
		end else begin
			tx_start    <= 1'b0;
			frm.confirm <= 1'b0;
			case (state)
				link_idle: begin
					if (frm.shot) begin
						state <= link_load;
					end
				end
				link_load: begin
					state <= link_send;
				end
				link_send: begin
					if (dsr) begin
						error    <= 1'b0;
						tx_start <= 1'b1;
						state    <= link_wait_end;
					end else begin
						// remote not ready, frame is lost
						error       <= 1'b1;
						frm.confirm <= 1'b1;
						state       <= link_idle;
					end
				end
				link_wait_end: begin
					if (tx_done) begin
						frm.confirm <= 1'b1;
						state       <= link_idle;
					end
				end
				default: state <= link_idle;
			endcase
		end
	end

	// frame captured in the load cycle
	always_ff @(posedge clock) begin
		if (state == link_load) begin
			hold_reg <= frm.frame;
		end
	end

endmodule

`default_nettype wire

/* logic/uart_serializer.sv */
// asynchronous serializer, one start bit, 8 data bits MSB first, one stop bit
// each bit lasts ADC_LINK_BIT_TICKS+1 clocks, no parity
// start is ignored while a byte is still on the line
`include "adc_link_config.svh"
`timescale 1ns/1ps
`default_nettype none

module uart_serializer import adc_link_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       start,
	input  logic [7:0] data,
	output logic       done,
	output logic       data_out
);

	localparam int tick_w = $clog2(`ADC_LINK_BIT_TICKS + 1);
	localparam logic [tick_w-1:0] tick_max = tick_w'(`ADC_LINK_BIT_TICKS);

	tx_bit_t           bit_pos;
	logic              active;
	logic [tick_w-1:0] tick;
	logic [7:0]        shreg;
	logic              bit_end;

	// last clock of the current bit
	assign bit_end = active && (tick == tick_max);
	// pulse in the final cycle of the stop bit
	assign done = bit_end && (bit_pos == tx_stop);

	always_ff @(posedge clock) begin
		if (reset) begin
			active   <= 1'b0;
			bit_pos  <= tx_start;
			tick     <= '0;
			data_out <= 1'b1;
		end else if (!active) begin
			if (start) begin
				active   <= 1'b1;
				bit_pos  <= tx_start;
				tick     <= '0;
				// start bit
				data_out <= 1'b0;
			end
		end else if (!bit_end) begin
			tick <= tick + 1'b1;
		end else begin
			tick <= '0;
			case (bit_pos)
				tx_stop: begin
					// line stays idle high
					active  <= 1'b0;
					bit_pos <= tx_start;
				end
				tx_bit7: begin
					data_out <= 1'b1;
					bit_pos  <= tx_stop;
				end
				default: begin
					data_out <= shreg[7];
					bit_pos  <= tx_bit_t'(bit_pos + 1'b1);
				end
			endcase
		end
	end

	// shift register, MSB leaves first
	always_ff @(posedge clock) begin
		if (!active && start) begin
			shreg <= data;
		end else if (bit_end && bit_pos != tx_stop && bit_pos != tx_bit7) begin
			shreg <= {shreg[6:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# builds the ADC link testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f filelist.f --top-module adc_link_tb \
	-o adc_link_sim; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/adc_link_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q "ALL TESTS PASSED"; then
	exit 0
fi
exit 1
